/* hw/mem_side_consts.svh */
// Memory side constants for widths, DRAM geometry and latency, and host register map
`ifndef MEM_SIDE_CONSTS_SVH
`define MEM_SIDE_CONSTS_SVH

// Command and data widths
`define MEM_ADDR_WIDTH 16
`define MEM_DATA_WIDTH 32

// Everything below the base is host MMIO
`define DRAM_BASE_ADDR 16'h8000

// DRAM words, index wraps modulo this count
`define DRAM_WORDS 256

// Cycles from command transfer to response valid
`define DRAM_LATENCY 3

// Host register map
`define HOST_FINISH_ADDR 16'h0010
`define HOST_COUNT_ADDR  16'h0020

`define EXIT_CODE_WIDTH 8

`endif

/* hw/mem_side_pkg.sv */
// Memory side package with the shared vector types and the DRAM FSM states
`default_nettype none

`include "mem_side_consts.svh"

package mem_side_pkg;

  // Command address
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // Data word on commands and responses
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;

  // Program exit code held by the host block
  typedef logic [`EXIT_CODE_WIDTH-1:0] exit_code_t;

  // DRAM model FSM
  typedef enum logic [1:0]
  {
    DRAM_IDLE = 2'd0,
    DRAM_WAIT = 2'd1,
    DRAM_RESP = 2'd2
  } dram_state_e;

endpackage : mem_side_pkg

`default_nettype wire

/* hw/mem_cmd_split.sv */
// Command splitter routing by address to host or DRAM, one request in flight, response merge
`default_nettype none

`include "mem_side_consts.svh"

module mem_cmd_split
  (input  logic                    clk_i
   , input  logic                  reset_i

   // External command
   , input  logic                  cmd_v_i
   , input  logic                  cmd_we_i
   , input  mem_side_pkg::mem_addr_t cmd_addr_i
   , input  mem_side_pkg::mem_data_t cmd_data_i
   , output logic                  cmd_ready_o

   // External response
   , output logic                  resp_v_o
   , output mem_side_pkg::mem_data_t resp_data_o
   , input  logic                  resp_ready_i

   // DRAM target
   , output logic                  dram_cmd_v_o
   , input  logic                  dram_cmd_ready_i
   , input  logic                  dram_resp_v_i
   , input  mem_side_pkg::mem_data_t dram_resp_data_i

   // Host target
   , output logic                  host_cmd_v_o
   , input  logic                  host_cmd_ready_i
   , input  logic                  host_resp_v_i
   , input  mem_side_pkg::mem_data_t host_resp_data_i

   // Payload and ready shared by both targets
   , output logic                  fwd_we_o
   , output mem_side_pkg::mem_addr_t fwd_addr_o
   , output mem_side_pkg::mem_data_t fwd_data_o
   , output logic                  resp_ready_o
   );

  logic to_host;
  logic outstanding_r;
  logic cmd_fire;
  logic resp_fire;

  assign to_host = (cmd_addr_i < `DRAM_BASE_ADDR);

  // Valid goes only to the decoded target
  assign host_cmd_v_o = cmd_v_i & to_host & ~outstanding_r;
  assign dram_cmd_v_o = cmd_v_i & ~to_host & ~outstanding_r;
  assign cmd_ready_o  = (to_host ? host_cmd_ready_i : dram_cmd_ready_i) & ~outstanding_r;

  assign fwd_we_o   = cmd_we_i;
  assign fwd_addr_o = cmd_addr_i;
  assign fwd_data_o = cmd_data_i;

  // Host wins, though both never fire together
  assign resp_v_o     = host_resp_v_i | dram_resp_v_i;
  assign resp_data_o  = host_resp_v_i ? host_resp_data_i : dram_resp_data_i;
  assign resp_ready_o = resp_ready_i;

  assign cmd_fire  = cmd_v_i & cmd_ready_o;
  assign resp_fire = resp_v_o & resp_ready_i;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        outstanding_r <= 1'b0;
      else if (cmd_fire)
        outstanding_r <= 1'b1;
      else if (resp_fire)
        outstanding_r <= 1'b0;
    end

endmodule : mem_cmd_split

`default_nettype wire

/* hw/mem_dram_model.sv */
// DRAM model with a word array that answers each command after a fixed latency
`default_nettype none

`include "mem_side_consts.svh"

module mem_dram_model
  (input  logic                    clk_i
   , input  logic                  reset_i

   , input  logic                  cmd_v_i
   , output logic                  cmd_ready_o
   , input  logic                  cmd_we_i
   , input  mem_side_pkg::mem_addr_t cmd_addr_i
   , input  mem_side_pkg::mem_data_t cmd_data_i

   , output logic                  resp_v_o
   , output mem_side_pkg::mem_data_t resp_data_o
   , input  logic                  resp_ready_i
   );

  import mem_side_pkg::*;

  dram_state_e state_r;
  logic [7:0]  wait_cnt_r;
  logic        cmd_fire;

  mem_addr_t                        dram_offset;
  logic [$clog2(`DRAM_WORDS)-1:0]   dram_idx;

  mem_data_t mem_r [`DRAM_WORDS];
  mem_data_t resp_data_r;

  // Offset from base, low bits wrap the array
  assign dram_offset = cmd_addr_i - `DRAM_BASE_ADDR;
  assign dram_idx    = dram_offset[$clog2(`DRAM_WORDS)-1:0];

  assign cmd_ready_o = (state_r == DRAM_IDLE);
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  assign resp_v_o    = (state_r == DRAM_RESP);
  assign resp_data_o = resp_data_r;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          state_r    <= DRAM_IDLE;
          wait_cnt_r <= '0;
        end
      else
        begin
          case (state_r)
            DRAM_IDLE:
              if (cmd_fire)
                begin
                  state_r    <= DRAM_WAIT;
                  wait_cnt_r <= 8'(`DRAM_LATENCY - 1);
                end
            // Last wait cycle raises valid for the next edge
            DRAM_WAIT:
              if (wait_cnt_r == 8'd1)
                state_r <= DRAM_RESP;
              else
                wait_cnt_r <= wait_cnt_r - 8'd1;
            DRAM_RESP:
              if (resp_ready_i)
                state_r <= DRAM_IDLE;
            default:
              state_r <= DRAM_IDLE;
          endcase
        end
    end

  // Array write and response capture at acceptance
  always_ff @(posedge clk_i)
    begin
      if (cmd_fire)
        begin
          if (cmd_we_i)
            mem_r[dram_idx] <= cmd_data_i;
          resp_data_r <= cmd_we_i ? '0 : mem_r[dram_idx];
        end
    end

endmodule : mem_dram_model

`default_nettype wire

/* hw/mem_host_mmio.sv */
// Host MMIO block with the finish register, exit code and host write counter
`default_nettype none

`include "mem_side_consts.svh"

module mem_host_mmio
  (input  logic                    clk_i
   , input  logic                  reset_i

   , input  logic                  cmd_v_i
   , output logic                  cmd_ready_o
   , input  logic                  cmd_we_i
   , input  mem_side_pkg::mem_addr_t cmd_addr_i
   , input  mem_side_pkg::mem_data_t cmd_data_i

   , output logic                  resp_v_o
   , output mem_side_pkg::mem_data_t resp_data_o
   , input  logic                  resp_ready_i

   , output logic                  program_finish_o
   , output mem_side_pkg::exit_code_t exit_code_o
   );

  import mem_side_pkg::*;

  logic       resp_v_r;
  mem_data_t  resp_data_r;
  mem_data_t  host_count_r;
  mem_data_t  rd_data;
  exit_code_t exit_code_r;
  logic       finish_r;
  logic       cmd_fire;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  // Register read mux
  always_comb
    begin
      if (cmd_addr_i == `HOST_COUNT_ADDR)
        rd_data = host_count_r;
      else if (cmd_addr_i == `HOST_FINISH_ADDR)
        rd_data = mem_data_t'(exit_code_r);
      else
        rd_data = '0;
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          resp_v_r     <= 1'b0;
          host_count_r <= '0;
          exit_code_r  <= '0;
          finish_r     <= 1'b0;
        end
      else
        begin
          if (cmd_fire)
            resp_v_r <= 1'b1;
          else if (resp_ready_i)
            resp_v_r <= 1'b0;

          if (cmd_fire & cmd_we_i)
            begin
              host_count_r <= host_count_r + 1'b1;
              // Finish is sticky until reset
              if (cmd_addr_i == `HOST_FINISH_ADDR)
                begin
                  finish_r    <= 1'b1;
                  exit_code_r <= cmd_data_i[`EXIT_CODE_WIDTH-1:0];
                end
            end
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (cmd_fire)
        resp_data_r <= cmd_we_i ? '0 : rd_data;
    end

  assign resp_v_o         = resp_v_r;
  assign resp_data_o      = resp_data_r;
  assign program_finish_o = finish_r;
  assign exit_code_o      = exit_code_r;

endmodule : mem_host_mmio

`default_nettype wire

/* hw/mem_side_top.sv */
// Memory side top level joining the command splitter, DRAM model and host MMIO
`default_nettype none

module mem_side_top
  (input  logic                    clk_i
   , input  logic                  reset_i

   , input  logic                  cmd_v_i
   , input  logic                  cmd_we_i
   , input  mem_side_pkg::mem_addr_t cmd_addr_i
   , input  mem_side_pkg::mem_data_t cmd_data_i
   , output logic                  cmd_ready_o

   , output logic                  resp_v_o
   , output mem_side_pkg::mem_data_t resp_data_o
   , input  logic                  resp_ready_i

   , output logic                  program_finish_o
   , output mem_side_pkg::exit_code_t exit_code_o
   );

  import mem_side_pkg::*;

  logic      dram_cmd_v, dram_cmd_ready, dram_resp_v;
  mem_data_t dram_resp_data;
  logic      host_cmd_v, host_cmd_ready, host_resp_v;
  mem_data_t host_resp_data;

  // Shared payload toward both targets
  logic      fwd_we;
  mem_addr_t fwd_addr;
  mem_data_t fwd_data;
  logic      resp_ready;

  mem_cmd_split i_split
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_we_i(cmd_we_i)
     ,.cmd_addr_i(cmd_addr_i)
     ,.cmd_data_i(cmd_data_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_data_o(resp_data_o)
     ,.resp_ready_i(resp_ready_i)
     ,.dram_cmd_v_o(dram_cmd_v)
     ,.dram_cmd_ready_i(dram_cmd_ready)
     ,.dram_resp_v_i(dram_resp_v)
     ,.dram_resp_data_i(dram_resp_data)
     ,.host_cmd_v_o(host_cmd_v)
     ,.host_cmd_ready_i(host_cmd_ready)
     ,.host_resp_v_i(host_resp_v)
     ,.host_resp_data_i(host_resp_data)
     ,.fwd_we_o(fwd_we)
     ,.fwd_addr_o(fwd_addr)
     ,.fwd_data_o(fwd_data)
     ,.resp_ready_o(resp_ready)
     );

  mem_dram_model i_dram
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(dram_cmd_v)
     ,.cmd_ready_o(dram_cmd_ready)
     ,.cmd_we_i(fwd_we)
     ,.cmd_addr_i(fwd_addr)
     ,.cmd_data_i(fwd_data)
     ,.resp_v_o(dram_resp_v)
     ,.resp_data_o(dram_resp_data)
     ,.resp_ready_i(resp_ready)
     );

  mem_host_mmio i_host
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(host_cmd_v)
     ,.cmd_ready_o(host_cmd_ready)
     ,.cmd_we_i(fwd_we)
     ,.cmd_addr_i(fwd_addr)
     ,.cmd_data_i(fwd_data)
     ,.resp_v_o(host_resp_v)
     ,.resp_data_o(host_resp_data)
     ,.resp_ready_i(resp_ready)
     ,.program_finish_o(program_finish_o)
     ,.exit_code_o(exit_code_o)
     );

endmodule : mem_side_top

`default_nettype wire

/* sim/mem_side_properties.sv */
// Handshake properties on the memory side top level ports
`default_nettype none

module mem_side_properties
  (input  logic                    clk_i
   , input logic                   reset_i
   , input logic                   cmd_v_i
   , input logic                   cmd_ready_i
   , input logic                   resp_v_i
   , input mem_side_pkg::mem_data_t resp_data_i
   , input logic                   resp_ready_i
   , input logic                   program_finish_i
   );

  // Response holds its payload under back-pressure
  resp_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_data_i))
    else $error("response dropped or changed before ready");

  resp_block_a : assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_i |-> !cmd_ready_i)
    else $error("command port ready while a response is pending");

  // Only one request in flight
  one_inflight_a : assert property (@(posedge clk_i) disable iff (reset_i)
      cmd_v_i && cmd_ready_i |=> !cmd_ready_i)
    else $error("command accepted right after another command");

  finish_sticky_a : assert property (@(posedge clk_i) disable iff (reset_i)
      program_finish_i |=> program_finish_i)
    else $error("program finish flag fell without reset");

endmodule : mem_side_properties

bind mem_side_top mem_side_properties i_props
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.cmd_v_i(cmd_v_i)
   ,.cmd_ready_i(cmd_ready_o)
   ,.resp_v_i(resp_v_o)
   ,.resp_data_i(resp_data_o)
   ,.resp_ready_i(resp_ready_i)
   ,.program_finish_i(program_finish_o)
   );

`default_nettype wire

/* sim/mem_side_tb.sv */
// Testbench for the memory side top level with random traffic checked against a reference model
`default_nettype none

`include "mem_side_consts.svh"

module mem_side_tb;

  import mem_side_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_LAT      = 24;
  localparam int N_HOST     = 40;
  localparam int N_MIX      = 300;
  localparam int N_OPS      = `DRAM_WORDS + N_LAT + N_HOST + N_MIX + 2;

  typedef logic [$clog2(`DRAM_WORDS)-1:0] dram_idx_t;

  logic        clk;
  logic        reset;
  logic        cmd_v;
  logic        cmd_we;
  mem_addr_t   cmd_addr;
  mem_data_t   cmd_data;
  logic        cmd_ready;
  logic        resp_v;
  mem_data_t   resp_data;
  logic        resp_ready;
  logic        program_finish;
  exit_code_t  exit_code;

  // Reference state
  mem_data_t   shadow_dram [`DRAM_WORDS];
  mem_data_t   shadow_count;
  exit_code_t  shadow_exit;

  mem_data_t   exp_q [$];
  string       name_q [$];
  mem_data_t   pop_exp;
  string       pop_name;
  string       test_name;
  int          cycle;
  int          issue_cycle;
  logic        issue_dram;
  logic        resp_seen;
  int          errors;
  int          checks;
  integer      seed;
  integer      ready_seed;
  logic        rand_ready;
  int          hold_cnt;
  logic [31:0] ready_rand;
  logic [31:0] r;
  mem_data_t   wdata;

  mem_side_top i_dut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.cmd_v_i(cmd_v)
     ,.cmd_we_i(cmd_we)
     ,.cmd_addr_i(cmd_addr)
     ,.cmd_data_i(cmd_data)
     ,.cmd_ready_o(cmd_ready)
     ,.resp_v_o(resp_v)
     ,.resp_data_o(resp_data)
     ,.resp_ready_i(resp_ready)
     ,.program_finish_o(program_finish)
     ,.exit_code_o(exit_code)
     );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Expected response data, updates the shadow state as a side effect
  function automatic mem_data_t predict_resp(input logic we, input mem_addr_t addr,
                                             input mem_data_t data);
    mem_addr_t offset;
    dram_idx_t idx;
    mem_data_t result;
    result = '0;
    if (addr >= `DRAM_BASE_ADDR)
      begin
        offset = addr - `DRAM_BASE_ADDR;
        idx    = dram_idx_t'(int'(offset) % `DRAM_WORDS);
        if (we)
          shadow_dram[idx] = data;
        else
          result = shadow_dram[idx];
      end
    else if (we)
      begin
        shadow_count = shadow_count + 1;
        if (addr == `HOST_FINISH_ADDR)
          shadow_exit = data[`EXIT_CODE_WIDTH-1:0];
      end
    else if (addr == `HOST_COUNT_ADDR)
      result = shadow_count;
    else if (addr == `HOST_FINISH_ADDR)
      result = mem_data_t'(shadow_exit);
    return result;
  endfunction

  // Upper address bits spread reads and writes over aliases of each word
  function automatic mem_addr_t dram_addr(input logic [31:0] rnd);
    return `DRAM_BASE_ADDR | {1'b0, rnd[14:0]};
  endfunction

  // Host address that never touches the finish register
  function automatic mem_addr_t host_addr(input logic [31:0] rnd);
    mem_addr_t a;
    a = rnd[16] ? `HOST_COUNT_ADDR : {1'b0, rnd[14:0]};
    if (a == `HOST_FINISH_ADDR)
      a = `HOST_COUNT_ADDR;
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
      begin
        errors++;
        $display("ERR %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic issue(input logic we, input mem_addr_t addr, input mem_data_t data);
    cmd_v    = 1'b1;
    cmd_we   = we;
    cmd_addr = addr;
    cmd_data = data;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  // Latency, ordering and data of every response
  always @(posedge clk)
    begin
      cycle = cycle + 1;
      if (!reset)
        begin
          if (cmd_ready && exp_q.size() != 0)
            begin
              errors++;
              $display("Command port ready while a response is pending, cycle %0d", cycle);
            end
          if (resp_v && !resp_seen && exp_q.size() != 0)
            begin
              resp_seen = 1'b1;
              if (issue_dram)
                check_value("dram_latency", `DRAM_LATENCY, cycle - issue_cycle);
              else
                check_value("host_latency", 1, cycle - issue_cycle);
            end
          if (resp_v && resp_ready)
            begin
              if (exp_q.size() == 0)
                begin
                  errors++;
                  $display("Response returned with no request outstanding, cycle %0d", cycle);
                end
              else
                begin
                  pop_exp  = exp_q.pop_front();
                  pop_name = name_q.pop_front();
                  check_value(pop_name, pop_exp, resp_data);
                end
            end
          if (cmd_v && cmd_ready)
            begin
              exp_q.push_back(predict_resp(cmd_we, cmd_addr, cmd_data));
              name_q.push_back(test_name);
              issue_cycle = cycle;
              issue_dram  = (cmd_addr >= `DRAM_BASE_ADDR);
              resp_seen   = 1'b0;
            end
        end
    end

  // Back-pressure with single low cycles and longer held stretches
  always @(negedge clk)
    begin
      if (!rand_ready)
        resp_ready = 1'b1;
      else if (hold_cnt > 0)
        begin
          resp_ready = 1'b0;
          hold_cnt   = hold_cnt - 1;
        end
      else
        begin
          ready_rand = $random(ready_seed);
          if (ready_rand[3:0] == 4'd0)
            begin
              hold_cnt   = 2 + int'(ready_rand[6:4]);
              resp_ready = 1'b0;
            end
          else
            resp_ready = (ready_rand[9:8] != 2'd0);
        end
    end

  initial
    begin
      repeat (N_OPS * (`DRAM_LATENCY + 10)) @(posedge clk);
      $display("Timeout: DUT stopped accepting commands or returning responses");
      $display("Testbench failed");
      $finish;
    end

  initial
    begin
      clk          = 1'b0;
      reset        = 1'b1;
      cmd_v        = 1'b0;
      cmd_we       = 1'b0;
      cmd_addr     = '0;
      cmd_data     = '0;
      resp_ready   = 1'b1;
      seed         = 91;
      ready_seed   = seed + 1;
      rand_ready   = 1'b0;
      hold_cnt     = 0;
      shadow_count = '0;
      shadow_exit  = '0;
      errors       = 0;
      checks       = 0;
      cycle        = 0;
      resp_seen    = 1'b1;
      test_name    = "reset";
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_value("reset_resp_v", 0, resp_v);
      check_value("reset_finish", 0, program_finish);
      check_value("reset_exit_code", 0, exit_code);

      // Every DRAM word gets a known value first
      test_name = "dram_fill";
      for (int i = 0; i < `DRAM_WORDS; i++)
        begin
          wdata = $random(seed);
          issue(1'b1, `DRAM_BASE_ADDR + mem_addr_t'(i), wdata);
        end

      test_name = "latency";
      for (int i = 0; i < N_LAT; i++)
        begin
          r     = $random(seed);
          wdata = $random(seed);
          if (i % 2 == 0)
            issue(r[31], dram_addr(r), wdata);
          else
            issue(r[31], host_addr(r), wdata);
        end

      test_name = "host_regs";
      for (int i = 0; i < N_HOST; i++)
        begin
          r     = $random(seed);
          wdata = $random(seed);
          issue(r[31], host_addr(r), wdata);
        end
      wait_idle();

      test_name  = "mixed_backpressure";
      rand_ready = 1'b1;
      for (int i = 0; i < N_MIX; i++)
        begin
          r     = $random(seed);
          wdata = $random(seed);
          if (r[30])
            issue(r[31], dram_addr(r), wdata);
          else
            issue(r[31], host_addr(r), wdata);
        end
      wait_idle();
      rand_ready = 1'b0;

      test_name = "finish";
      wdata     = $random(seed);
      issue(1'b1, `HOST_FINISH_ADDR, wdata);
      wait_idle();
      check_value("finish_flag", 1, program_finish);
      check_value("exit_code", {24'd0, wdata[7:0]}, {24'd0, exit_code});
      issue(1'b0, `HOST_FINISH_ADDR, '0);
      wait_idle();

      repeat (2) @(negedge clk);
      $display("mem_side_tb: %0d errors in %0d checks", errors, checks);
      if (errors == 0)
        $display("Testbench passed");
      else
        $display("Testbench failed");
      $finish;
    end

endmodule : mem_side_tb

`default_nettype wire

/* mem_side_top.f */
+incdir+hw
hw/mem_side_pkg.sv
hw/mem_cmd_split.sv
hw/mem_dram_model.sv
hw/mem_host_mmio.sv
hw/mem_side_top.sv
sim/mem_side_properties.sv
sim/mem_side_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory side testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_side_tb -f mem_side_top.f -o Vmem_side_tb

status=0
./obj_dir/Vmem_side_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  exit "$status"
fi
grep -q "Testbench passed" sim.log
